// File: rtl/cpu_pkg.sv
package cpu_pkg;

    // ------------------------------
    // Data widths
    // ------------------------------
    typedef logic [15:0] word_t;
    typedef logic [3:0]  reg_idx_t;
    typedef logic [3:0]  opcode_t;
    typedef logic [4:0]  flags_t;
    typedef logic [3:0]  cond_t;

    // ------------------------------
    // Opcodes, top nibble of the instruction
    // ------------------------------
    localparam opcode_t OP_ADD   = 4'd0;
    localparam opcode_t OP_ADDI  = 4'd1;
    localparam opcode_t OP_SUB   = 4'd2;
    localparam opcode_t OP_CMP   = 4'd3;
    localparam opcode_t OP_AND   = 4'd4;
    localparam opcode_t OP_OR    = 4'd5;
    localparam opcode_t OP_XOR   = 4'd6;
    localparam opcode_t OP_MOV   = 4'd7;
    localparam opcode_t OP_MOVI  = 4'd8;
    localparam opcode_t OP_LSH   = 4'd9;
    localparam opcode_t OP_LOAD  = 4'd10;
    localparam opcode_t OP_STOR  = 4'd11;
    localparam opcode_t OP_BCOND = 4'd12;
    localparam opcode_t OP_JUMP  = 4'd13;
    localparam opcode_t OP_HALT  = 4'd15;

    // Bit positions in the flag word
    localparam int FLAG_Z = 0;
    localparam int FLAG_N = 1;
    localparam int FLAG_L = 2;
    localparam int FLAG_C = 3;
    localparam int FLAG_F = 4;

    // Branch conditions, other codes never branch
    localparam cond_t COND_EQ = 4'd0;
    localparam cond_t COND_NE = 4'd1;
    localparam cond_t COND_LT = 4'd2;
    localparam cond_t COND_LO = 4'd3;
    localparam cond_t COND_AL = 4'd4;

    typedef enum logic [2:0] {
        IDLE,
        FETCH,
        DECODE,
        EXECUTE,
        MEMORY,
        HALTED
    } cpu_state_t;

endpackage

// File: rtl/dual_port_ram.sv
`timescale 1ns/1ns

module dual_port_ram import cpu_pkg::*; #(
    parameter int ADDR_WIDTH = 8
) (
    input  logic  clk,
    input  word_t addr_a,
    input  word_t addr_b,
    input  word_t data_a,
    input  word_t data_b,
    input  logic  we_a,
    input  logic  we_b,
    output word_t q_a,
    output word_t q_b
);

    localparam int DEPTH = 1 << ADDR_WIDTH;

    word_t mem [DEPTH];

    logic [ADDR_WIDTH-1:0] idx_a;
    logic [ADDR_WIDTH-1:0] idx_b;

    // Upper address bits are ignored
    assign idx_a = addr_a[ADDR_WIDTH-1:0];
    assign idx_b = addr_b[ADDR_WIDTH-1:0];

    // Both ports in one process
    // Same-address write collision goes to port B
    always_ff @(posedge clk) begin
        if (we_a) begin
            mem[idx_a] <= data_a;
        end
        if (we_b) begin
            mem[idx_b] <= data_b;
        end
        // Read before write, old data on a write cycle
        q_a <= mem[idx_a];
        q_b <= mem[idx_b];
    end

endmodule

// File: rtl/program_counter.sv
`timescale 1ns/1ns

module program_counter import cpu_pkg::*; #(
    parameter int ADDR_WIDTH = 8
) (
    input  logic  clk,
    input  logic  reset,
    input  logic  en,
    input  logic  pc_mux,
    input  logic  pc_load,
    input  word_t disp,
    input  word_t tgt_addr,
    output word_t pc
);

    // Keeps the pc inside the RAM
    localparam word_t ADDR_MASK = word_t'((1 << ADDR_WIDTH) - 1);

    word_t pc_next;

    // Register target wins over displacement
    always_comb begin
        if (pc_load) begin
            pc_next = tgt_addr;
        end else if (pc_mux) begin
            pc_next = pc + disp;
        end else begin
            pc_next = pc + 16'd1;
        end
    end

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            pc <= '0;
        end else if (en) begin
            pc <= pc_next & ADDR_MASK;
        end
    end

endmodule

// File: rtl/control_decoder.sv
`timescale 1ns/1ns

module control_decoder import cpu_pkg::*; (
    input  logic     clk,
    input  logic     reset,
    input  logic     run,
    input  word_t    q_a,
    input  word_t    pc,
    input  word_t    rsrc_data,
    input  flags_t   flags_next,
    output opcode_t  op,
    output reg_idx_t rdest,
    output reg_idx_t rsrc,
    output word_t    imm,
    output logic     imm_sel,
    output logic     reg_we,
    output logic     wb_sel,
    output logic     mem_we,
    output logic     pc_en,
    output logic     pc_mux,
    output logic     pc_load,
    output word_t    disp,
    output word_t    mem_addr,
    output logic     carry_in,
    output logic     halted
);

    cpu_state_t state;
    cpu_state_t state_next;
    word_t      ir;
    flags_t     flags;
    cond_t      cond;
    logic       taken;
    logic       alu_write;
    logic       flag_write;
    logic       mem_sel;

    // ------------------------------
    // Instruction fields
    // ------------------------------
    assign op    = opcode_t'(ir[15:12]);
    assign rdest = ir[11:8];
    assign rsrc  = ir[7:4];
    assign cond  = ir[11:8];

    // Low byte, sign extended except for MOVI
    assign disp    = {{8{ir[7]}}, ir[7:0]};
    assign imm     = (op == OP_MOVI) ? {8'h00, ir[7:0]} : disp;
    assign imm_sel = (op == OP_ADDI) || (op == OP_MOVI);

    // Which ops write rdest from the ALU, and which update flags
    always_comb begin
        case (op)
            OP_ADD, OP_ADDI, OP_SUB, OP_LSH: begin
                alu_write  = 1'b1;
                flag_write = 1'b1;
            end
            OP_CMP: begin
                alu_write  = 1'b0;
                flag_write = 1'b1;
            end
            OP_AND, OP_OR, OP_XOR, OP_MOV, OP_MOVI: begin
                alu_write  = 1'b1;
                flag_write = 1'b0;
            end
            default: begin
                alu_write  = 1'b0;
                flag_write = 1'b0;
            end
        endcase
    end

    // Branch condition against the stored flags
    always_comb begin
        case (cond)
            COND_EQ: taken = flags[FLAG_Z];
            COND_NE: taken = !flags[FLAG_Z];
            COND_LT: taken = flags[FLAG_N];
            COND_LO: taken = flags[FLAG_L];
            COND_AL: taken = 1'b1;
            default: taken = 1'b0;
        endcase
    end

    // ------------------------------
    // State machine
    // ------------------------------
    always_comb begin
        state_next = state;
        case (state)
            IDLE: begin
                if (run) begin
                    state_next = FETCH;
                end
            end
            FETCH:  state_next = DECODE;
            DECODE: state_next = EXECUTE;
            EXECUTE: begin
                if (op == OP_HALT) begin
                    state_next = HALTED;
                end else if (op == OP_LOAD) begin
                    state_next = MEMORY;
                end else begin
                    state_next = FETCH;
                end
            end
            MEMORY: state_next = FETCH;
            HALTED: state_next = HALTED;
            default: state_next = IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            state <= IDLE;
            ir    <= '0;
            flags <= '0;
        end else begin
            state <= state_next;
            // RAM output holds the word fetched in the previous cycle
            if (state == DECODE) begin
                ir <= q_a;
            end
            if (state == EXECUTE && flag_write) begin
                flags <= flags_next;
            end
        end
    end

    // ------------------------------
    // Control outputs
    // ------------------------------
    // Port A address, pc for fetch, rsrc for load and store
    assign mem_sel  = (state == EXECUTE) && ((op == OP_LOAD) || (op == OP_STOR));
    assign mem_addr = mem_sel ? rsrc_data : pc;
    assign mem_we   = (state == EXECUTE) && (op == OP_STOR);

    // Load data lands in MEMORY, one cycle after the address
    assign reg_we = ((state == EXECUTE) && alu_write) || (state == MEMORY);
    assign wb_sel = (state == MEMORY);

    assign pc_en   = (state == EXECUTE) && (op != OP_HALT);
    assign pc_mux  = (op == OP_BCOND) && taken;
    assign pc_load = (op == OP_JUMP);

    assign carry_in = flags[FLAG_C];
    assign halted   = (state == HALTED);

endmodule

// File: rtl/alu.sv
`timescale 1ns/1ns

module alu import cpu_pkg::*; (
    input  word_t   a,
    input  word_t   b,
    input  opcode_t op,
    input  logic    carry_in,
    output word_t   result,
    output flags_t  flags_next
);

    logic [16:0] sum;
    logic [16:0] diff;
    word_t       shift_mag;
    logic        cin;

    always_comb begin
        // Carry chains only through register ADD
        cin       = (op == OP_ADD) && carry_in;
        sum       = {1'b0, a} + {1'b0, b} + {16'd0, cin};
        diff      = {1'b0, a} - {1'b0, b};
        // Negative b shifts right by its magnitude
        shift_mag = b[15] ? (16'd0 - b) : b;

        flags_next = '0;
        case (op)
            OP_ADD, OP_ADDI: begin
                result             = sum[15:0];
                flags_next[FLAG_C] = sum[16];
                flags_next[FLAG_F] = (a[15] == b[15]) && (result[15] != a[15]);
            end
            OP_SUB, OP_CMP: begin
                result             = diff[15:0];
                flags_next[FLAG_C] = diff[16];
                flags_next[FLAG_F] = (a[15] != b[15]) && (result[15] != a[15]);
                flags_next[FLAG_N] = $signed(a) < $signed(b);
                flags_next[FLAG_L] = a < b;
            end
            OP_AND: result = a & b;
            OP_OR:  result = a | b;
            OP_XOR: result = a ^ b;
            OP_MOV, OP_MOVI: result = b;
            OP_LSH: begin
                if (b[15]) begin
                    result = a >> shift_mag[3:0];
                end else begin
                    result = a << shift_mag[3:0];
                end
            end
            default: result = '0;
        endcase

        flags_next[FLAG_Z] = (result == '0);
    end

endmodule

// File: rtl/writeback_regfile.sv
`timescale 1ns/1ns

module writeback_regfile import cpu_pkg::*; (
    input  logic     clk,
    input  logic     reset,
    input  logic     we,
    input  logic     wb_sel,
    input  reg_idx_t waddr,
    input  word_t    alu_result,
    input  word_t    mem_data,
    input  reg_idx_t raddr_a,
    input  reg_idx_t raddr_b,
    output word_t    rdata_a,
    output word_t    rdata_b
);

    word_t regs [16];
    word_t wdata;

    // Memory data for LOAD, ALU result otherwise
    assign wdata = wb_sel ? mem_data : alu_result;

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            for (int i = 0; i < 16; i++) begin
                regs[i] <= '0;
            end
        end else if (we) begin
            regs[waddr] <= wdata;
        end
    end

    // Port A is rdest, port B is rsrc
    assign rdata_a = regs[raddr_a];
    assign rdata_b = regs[raddr_b];

endmodule

// File: rtl/cpu_top.sv
`timescale 1ns/1ns

module cpu_top import cpu_pkg::*; #(
    parameter int ADDR_WIDTH = 8
) (
    input  logic  clk,
    input  logic  reset,
    input  logic  run,
    input  word_t host_addr,
    input  word_t host_wdata,
    input  logic  host_we,
    output word_t host_rdata,
    output logic  halted
);

    // Control from the decoder
    logic     pc_en;
    logic     pc_mux;
    logic     pc_load;
    logic     reg_we;
    logic     wb_sel;
    logic     mem_we;
    logic     imm_sel;
    logic     carry_in;
    opcode_t  op;
    reg_idx_t rdest;
    reg_idx_t rsrc;
    word_t    imm;
    word_t    disp;

    // Datapath
    word_t  pc;
    word_t  mem_addr;
    word_t  q_a;
    word_t  rdata_a;
    word_t  rdata_b;
    word_t  alu_b;
    word_t  alu_result;
    flags_t flags_next;

    // Immediate or rsrc into ALU operand B
    assign alu_b = imm_sel ? imm : rdata_b;

    // ------------------------------
    // Memory, port A to CPU, port B to host
    // ------------------------------
    dual_port_ram #(
        .ADDR_WIDTH(ADDR_WIDTH)
    ) u_ram (
        .clk   (clk),
        .addr_a(mem_addr),
        .addr_b(host_addr),
        .data_a(rdata_a),
        .data_b(host_wdata),
        .we_a  (mem_we),
        .we_b  (host_we),
        .q_a   (q_a),
        .q_b   (host_rdata)
    );

    program_counter #(
        .ADDR_WIDTH(ADDR_WIDTH)
    ) u_pc (
        .clk     (clk),
        .reset   (reset),
        .en      (pc_en),
        .pc_mux  (pc_mux),
        .pc_load (pc_load),
        .disp    (disp),
        .tgt_addr(rdata_b),
        .pc      (pc)
    );

    control_decoder u_ctrl (
        .clk       (clk),
        .reset     (reset),
        .run       (run),
        .q_a       (q_a),
        .pc        (pc),
        .rsrc_data (rdata_b),
        .flags_next(flags_next),
        .op        (op),
        .rdest     (rdest),
        .rsrc      (rsrc),
        .imm       (imm),
        .imm_sel   (imm_sel),
        .reg_we    (reg_we),
        .wb_sel    (wb_sel),
        .mem_we    (mem_we),
        .pc_en     (pc_en),
        .pc_mux    (pc_mux),
        .pc_load   (pc_load),
        .disp      (disp),
        .mem_addr  (mem_addr),
        .carry_in  (carry_in),
        .halted    (halted)
    );

    alu u_alu (
        .a         (rdata_a),
        .b         (alu_b),
        .op        (op),
        .carry_in  (carry_in),
        .result    (alu_result),
        .flags_next(flags_next)
    );

    writeback_regfile u_regs (
        .clk       (clk),
        .reset     (reset),
        .we        (reg_we),
        .wb_sel    (wb_sel),
        .waddr     (rdest),
        .alu_result(alu_result),
        .mem_data  (q_a),
        .raddr_a   (rdest),
        .raddr_b   (rsrc),
        .rdata_a   (rdata_a),
        .rdata_b   (rdata_b)
    );

endmodule

// File: verif/cpu_ref.svh
`ifndef CPU_REF_SVH
`define CPU_REF_SVH

// Instruction-level model of the CPU, included inside cpu_tb
// Runs on image and leaves the expected final memory in expect_mem

function automatic logic cond_met(logic [3:0] cond, flags_t fl);
    case (cond)
        COND_EQ: return fl[FLAG_Z];
        COND_NE: return !fl[FLAG_Z];
        COND_LT: return fl[FLAG_N];
        COND_LO: return fl[FLAG_L];
        COND_AL: return 1'b1;
        default: return 1'b0;
    endcase
endfunction

function automatic void alu_model(input opcode_t op, input word_t a, input word_t b,
                                  inout flags_t fl, output word_t res);
    int     s;
    int     sv;
    int     cin;
    word_t  mag;
    flags_t nf;
    nf  = '0;
    // Stored carry joins register adds only
    cin = (op == OP_ADD) ? int'(fl[FLAG_C]) : 0;
    case (op)
        OP_ADD, OP_ADDI: begin
            s   = int'(a) + int'(b) + cin;
            sv  = int'($signed(a)) + int'($signed(b)) + cin;
            res = s[15:0];
            nf[FLAG_C] = s[16];
            nf[FLAG_F] = (sv > 32767) || (sv < -32768);
        end
        OP_SUB, OP_CMP: begin
            sv  = int'($signed(a)) - int'($signed(b));
            res = a - b;
            nf[FLAG_F] = (sv > 32767) || (sv < -32768);
            nf[FLAG_N] = (sv < 0);
            nf[FLAG_L] = (a < b);
            // Borrow out
            nf[FLAG_C] = (a < b);
        end
        OP_AND:          res = a & b;
        OP_OR:           res = a | b;
        OP_XOR:          res = a ^ b;
        OP_MOV, OP_MOVI: res = b;
        OP_LSH: begin
            mag = 16'd0 - b;
            res = b[15] ? (a >> mag[3:0]) : (a << b[3:0]);
        end
        default: res = '0;
    endcase
    nf[FLAG_Z] = (res == 16'd0);
    if (op == OP_ADD || op == OP_ADDI || op == OP_SUB || op == OP_CMP || op == OP_LSH) begin
        fl = nf;
    end
endfunction

// Returns the number of instructions executed up to and including HALT
function automatic int cpu_run();
    word_t      r [16];
    flags_t     fl;
    logic [7:0] pc;
    word_t      ir;
    word_t      a;
    word_t      b;
    word_t      res;
    opcode_t    op;
    int         steps;
    logic       done;
    steps = 0;
    done  = 1'b0;
    fl    = '0;
    pc    = '0;
    for (int i = 0; i < 16; i++) begin
        r[i] = '0;
    end
    for (int i = 0; i < 256; i++) begin
        expect_mem[i] = image[i];
    end
    while (!done && steps < STEP_LIMIT) begin
        ir = expect_mem[pc];
        op = ir[15:12];
        a  = r[ir[11:8]];
        b  = r[ir[7:4]];
        steps++;
        // Immediate forms replace the source register
        if (op == OP_ADDI) begin
            b = {{8{ir[7]}}, ir[7:0]};
        end
        if (op == OP_MOVI) begin
            b = {8'h00, ir[7:0]};
        end
        case (op)
            OP_HALT: done = 1'b1;
            OP_LOAD: r[ir[11:8]] = expect_mem[b[7:0]];
            OP_STOR: expect_mem[b[7:0]] = a;
            OP_BCOND, OP_JUMP, 4'd14: ;
            default: begin
                alu_model(op, a, b, fl, res);
                if (op != OP_CMP) begin
                    r[ir[11:8]] = res;
                end
            end
        endcase
        if (op == OP_JUMP) begin
            pc = b[7:0];
        end else if (op == OP_BCOND && cond_met(ir[11:8], fl)) begin
            pc = pc + ir[7:0];
        end else if (!done) begin
            pc = pc + 8'd1;
        end
    end
    return steps;
endfunction

`endif

// File: verif/cpu_tb.sv
`timescale 1ns/1ns

module cpu_tb import cpu_pkg::*; ();

    localparam int NUM_TESTS   = 6;
    localparam int CLK_PERIOD  = 40;
    localparam int MAX_CYCLES  = 256 * 4;
    localparam int STEP_LIMIT  = 1024;
    localparam int WATCHDOG_NS = NUM_TESTS * 256 * 4 * CLK_PERIOD + NUM_TESTS * 8 * CLK_PERIOD;

    logic  clk;
    logic  reset;
    logic  run;
    word_t host_addr;
    word_t host_wdata;
    logic  host_we;
    word_t host_rdata;
    logic  halted;

    word_t  image [256];
    word_t  expect_mem [256];
    integer seed;
    int     pc_w;
    int     errors;
    int     test_errors;
    int     failed_tests;
    int     checks;
    int     cur_test;
    string  cur_name;

    `include "cpu_ref.svh"

    cpu_top #(
        .ADDR_WIDTH(8)
    ) UUT (
        .clk       (clk),
        .reset     (reset),
        .run       (run),
        .host_addr (host_addr),
        .host_wdata(host_wdata),
        .host_we   (host_we),
        .host_rdata(host_rdata),
        .halted    (halted)
    );

    initial clk = 1'b0;
    always #(CLK_PERIOD / 2) clk = ~clk;

    // ------------------------------
    // Program building
    // ------------------------------
    function automatic int rand_below(int n);
        integer r;
        r = $random(seed);
        return (r & 32'h7fffffff) % n;
    endfunction

    function automatic word_t rand_word();
        return word_t'(rand_below(65536));
    endfunction

    function automatic word_t rr_instr(opcode_t op, int rd, int rs);
        return {op, rd[3:0], rs[3:0], 4'h0};
    endfunction

    // Also used for BCOND, with the condition in the rdest field
    function automatic word_t imm_instr(opcode_t op, int rd, int imm);
        return {op, rd[3:0], imm[7:0]};
    endfunction

    task automatic emit(word_t w);
        image[pc_w] = w;
        pc_w++;
    endtask

    // Store a register at r12, then step r12
    task automatic store_reg(int r);
        emit(rr_instr(OP_STOR, r, 12));
        emit(imm_instr(OP_ADDI, 12, 1));
    endtask

    task automatic begin_test(int n, string name);
        cur_test    = n;
        cur_name    = name;
        test_errors = 0;
        pc_w        = 0;
        for (int a = 0; a < 256; a++) begin
            image[a] = word_t'(a * 257) ^ 16'h5A3C;
        end
    endtask

    // ------------------------------
    // DUT access
    // ------------------------------
    task automatic apply_reset();
        #2;
        reset = 1'b0;
        run   = 1'b0;
        host_we = 1'b0;
        repeat (8) @(posedge clk);
        #2;
        reset = 1'b1;
    endtask

    task automatic load_image();
        for (int a = 0; a < 256; a++) begin
            @(posedge clk);
            #2;
            host_we    = 1'b1;
            host_addr  = word_t'(a);
            host_wdata = image[a];
        end
        @(posedge clk);
        #2;
        host_we = 1'b0;
    endtask

    task automatic start_cpu();
        @(posedge clk);
        #2;
        run = 1'b1;
        @(posedge clk);
        #2;
        run = 1'b0;
    endtask

    task automatic wait_halted();
        int n;
        n = 0;
        while (halted !== 1'b1 && n < MAX_CYCLES) begin
            @(posedge clk);
            #2;
            n++;
        end
        checks++;
        if (halted !== 1'b1) begin
            $display("test %0d: CPU did not halt within %0d cycles", cur_test, MAX_CYCLES);
            test_errors++;
        end
    endtask

    task automatic check_halted_low();
        checks++;
        if (halted !== 1'b0) begin
            $display("ERR t=%0t halted got %b expected 0", $time, halted);
            test_errors++;
        end
    endtask

    // Read data comes one cycle after the address
    task automatic check_memory();
        for (int a = 0; a <= 256; a++) begin
            @(posedge clk);
            #2;
            if (a > 0) begin
                checks++;
                if (host_rdata !== expect_mem[a-1]) begin
                    $display("ERR t=%0t host_rdata[%0d] got %h expected %h",
                             $time, a - 1, host_rdata, expect_mem[a-1]);
                    test_errors++;
                end
            end
            if (a < 256) begin
                host_addr = word_t'(a);
            end
        end
    endtask

    task automatic finish_test();
        if (test_errors == 0) begin
            $display("test %0d %s: ok", cur_test, cur_name);
        end else begin
            $display("test %0d %s: %0d errors", cur_test, cur_name, test_errors);
            failed_tests++;
        end
        errors += test_errors;
    endtask

    task automatic run_and_check();
        int steps;
        apply_reset();
        load_image();
        steps = cpu_run();
        if (steps >= STEP_LIMIT) begin
            $display("test %0d: reference model did not reach HALT", cur_test);
            test_errors++;
        end
        start_cpu();
        wait_halted();
        check_memory();
        finish_test();
    endtask

    // ------------------------------
    // Tests
    // ------------------------------
    task automatic host_port_test();
        begin_test(1, "host port");
        apply_reset();
        check_halted_low();
        for (int a = 0; a < 256; a++) begin
            image[a]      = rand_word();
            expect_mem[a] = image[a];
        end
        load_image();
        check_memory();
        check_halted_low();
        finish_test();
    endtask

    task automatic alu_ops_test();
        begin_test(2, "alu ops");
        for (int i = 0; i < 6; i++) begin
            image['hC0 + i] = rand_word();
        end
        emit(imm_instr(OP_MOVI, 13, 'hC0));
        emit(imm_instr(OP_MOVI, 12, 'hE0));
        for (int r = 1; r <= 6; r++) begin
            emit(rr_instr(OP_LOAD, r, 13));
            emit(imm_instr(OP_ADDI, 13, 1));
        end
        for (int k = 0; k < 2; k++) begin
            emit(imm_instr(OP_MOVI, 7, rand_below(256)));
            store_reg(7);
            emit(rr_instr(OP_ADD, 1, 2));
            store_reg(1);
            emit(imm_instr(OP_ADDI, 3, rand_below(256)));
            store_reg(3);
            emit(rr_instr(OP_SUB, 2, 4));
            store_reg(2);
            emit(rr_instr(OP_AND, 4, 1));
            store_reg(4);
            emit(rr_instr(OP_OR, 5, 3));
            store_reg(5);
            emit(rr_instr(OP_XOR, 6, 5));
            store_reg(6);
            emit(rr_instr(OP_MOV, 8, 2));
            store_reg(8);
            emit(imm_instr(OP_MOVI, 9, rand_below(16)));
            emit(rr_instr(OP_LSH, 1, 9));
            store_reg(1);
            // Negative amount shifts right
            emit(imm_instr(OP_MOVI, 10, 0));
            emit(imm_instr(OP_ADDI, 10, -(1 + rand_below(15))));
            emit(rr_instr(OP_LSH, 6, 10));
            store_reg(6);
        end
        emit(rr_instr(OP_HALT, 0, 0));
        run_and_check();
    endtask

    task automatic load_store_test();
        begin_test(3, "load store");
        for (int i = 0; i < 8; i++) begin
            image['hC0 + i] = rand_word();
        end
        emit(imm_instr(OP_MOVI, 13, 'hC0));
        emit(imm_instr(OP_MOVI, 12, 'hE0));
        for (int i = 0; i < 8; i++) begin
            // Loaded register used by the very next instruction
            emit(rr_instr(OP_LOAD, 1, 13));
            emit(imm_instr(OP_ADDI, 1, rand_below(256)));
            store_reg(1);
            emit(rr_instr(OP_LOAD, 2, 13));
            emit(rr_instr(OP_ADD, 2, 1));
            store_reg(2);
            emit(imm_instr(OP_ADDI, 13, 1));
        end
        emit(rr_instr(OP_HALT, 0, 0));
        run_and_check();
    endtask

    task automatic branch_test();
        int    conds [7];
        int    c;
        word_t x;
        word_t y;
        begin_test(4, "branches");
        conds = '{0, 1, 2, 3, 4, 5, 15};
        x = rand_word();
        y = rand_word();
        if (x == y) begin
            y = y ^ 16'h0001;
        end
        image['hC0] = x;
        image['hC1] = y;
        emit(imm_instr(OP_MOVI, 13, 'hC0));
        emit(rr_instr(OP_LOAD, 1, 13));
        emit(imm_instr(OP_ADDI, 13, 1));
        emit(rr_instr(OP_LOAD, 2, 13));
        emit(rr_instr(OP_MOV, 3, 1));
        emit(imm_instr(OP_MOVI, 6, 'hE0));
        for (int i = 0; i < 7; i++) begin
            c = conds[i];
            // Forward displacement, unequal then equal operands
            for (int j = 0; j < 2; j++) begin
                emit(rr_instr(OP_CMP, 1, (j == 0) ? 2 : 3));
                emit(imm_instr(OP_MOVI, 5, 'h20 + c));
                emit(imm_instr(OP_BCOND, c, 2));
                emit(imm_instr(OP_MOVI, 5, 'h10 + c));
                emit(rr_instr(OP_STOR, 5, 6));
                emit(imm_instr(OP_ADDI, 6, 1));
            end
            // Backward displacement with swapped operands
            emit(rr_instr(OP_CMP, 2, 1));
            emit(imm_instr(OP_MOVI, 5, 'h10 + c));
            emit(imm_instr(OP_BCOND, 4, 3));
            emit(imm_instr(OP_MOVI, 5, 'h30 + c));
            emit(imm_instr(OP_BCOND, 4, 2));
            emit(imm_instr(OP_BCOND, c, -2));
            emit(rr_instr(OP_STOR, 5, 6));
            emit(imm_instr(OP_ADDI, 6, 1));
        end
        emit(rr_instr(OP_HALT, 0, 0));
        run_and_check();
    endtask

    task automatic jump_loop_test();
        int n;
        int target;
        int loop_start;
        begin_test(5, "jump and loop");
        n      = 1 + rand_below(40);
        target = 12 + rand_below(20);
        emit(imm_instr(OP_MOVI, 1, n));
        emit(imm_instr(OP_MOVI, 2, 0));
        emit(imm_instr(OP_MOVI, 3, 1));
        emit(imm_instr(OP_MOVI, 12, 'hE0));
        emit(imm_instr(OP_MOVI, 10, target));
        emit(rr_instr(OP_JUMP, 0, 10));
        // Only reached when the jump goes wrong
        emit(imm_instr(OP_MOVI, 4, 'hBA));
        emit(rr_instr(OP_STOR, 4, 12));
        emit(rr_instr(OP_HALT, 0, 0));
        while (pc_w < target) begin
            emit(16'hE000);
        end
        loop_start = pc_w;
        emit(rr_instr(OP_ADD, 2, 1));
        emit(rr_instr(OP_SUB, 1, 3));
        emit(imm_instr(OP_BCOND, 1, loop_start - pc_w));
        store_reg(2);
        store_reg(1);
        emit(imm_instr(OP_MOVI, 4, 'h5A));
        emit(rr_instr(OP_STOR, 4, 12));
        emit(rr_instr(OP_HALT, 0, 0));
        run_and_check();
    endtask

    task automatic carry_chain_test();
        begin_test(6, "carry chain");
        // Low words with top bits set always carry
        image['hC0] = rand_word() | 16'h8000;
        image['hC1] = rand_word();
        image['hC2] = rand_word() | 16'h8000;
        image['hC3] = rand_word();
        emit(imm_instr(OP_MOVI, 13, 'hC0));
        for (int r = 1; r <= 4; r++) begin
            emit(rr_instr(OP_LOAD, r, 13));
            emit(imm_instr(OP_ADDI, 13, 1));
        end
        emit(imm_instr(OP_MOVI, 12, 'hE0));
        emit(rr_instr(OP_CMP, 0, 0));
        emit(rr_instr(OP_ADD, 1, 3));
        emit(rr_instr(OP_ADD, 2, 4));
        store_reg(1);
        store_reg(2);
        emit(rr_instr(OP_HALT, 0, 0));
        run_and_check();
    endtask

    // ------------------------------
    // Main sequence and watchdog
    // ------------------------------
    initial begin
        seed         = 73;
        errors       = 0;
        failed_tests = 0;
        checks       = 0;
        cur_test     = 0;
        cur_name     = "reset";
        reset        = 1'b0;
        run          = 1'b0;
        host_addr    = '0;
        host_wdata   = '0;
        host_we      = 1'b0;
        host_port_test();
        alu_ops_test();
        load_store_test();
        branch_test();
        jump_loop_test();
        carry_chain_test();
        $display("%0d tests, %0d failed, %0d checks, %0d errors",
                 NUM_TESTS, failed_tests, checks, errors);
        if (errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired, test %0d (%s) hung", cur_test, cur_name);
        $display("Some tests failed");
        $finish;
    end

endmodule

// File: small_cpu.f
+incdir+verif
rtl/cpu_pkg.sv
rtl/dual_port_ram.sv
rtl/program_counter.sv
rtl/control_decoder.sv
rtl/alu.sv
rtl/writeback_regfile.sv
rtl/cpu_top.sv
verif/cpu_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the CPU testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -j 0 --top-module cpu_tb -f small_cpu.f -o cpu_sim
./obj_dir/cpu_sim > sim.log
cat sim.log

if grep -q "All tests passed" sim.log; then
    exit 0
fi
echo "simulation reported failures, see sim.log"
exit 1
